//--- bench/dmem_patterns.hex
// cmd width addr wdata exp_rdata exp_resp
// cmd 0 load 1 store, width 0 byte 1 half 2 word, resp 1 ok 2 error
1 2 00000010 cafef00d 00000000 1
0 2 00000010 00000000 cafef00d 1
1 2 00000020 a5a5a5a5 00000000 1
1 0 00000021 1234563c 00000000 1
1 1 00000022 9999beef 00000000 1
0 2 00000020 00000000 beef3ca5 1
1 0 00000027 00000012 00000000 1
1 1 00000024 00007788 00000000 1
0 2 00000024 00000000 12097788 1
0 0 00000023 00000000 000000be 1
0 0 00000021 00000000 0000003c 1
0 1 00000022 00000000 0000beef 1
0 1 00000024 00000000 00007788 1
0 2 00000080 00000000 df20df20 1
1 2 000003c0 deadbeef 00000000 2
0 2 00000010 00000000 cafef00d 1
0 0 000003c5 00000000 00000000 2
0 0 00000026 00000000 00000009 1

//--- list.f
common/dmem_ahb_pkg.sv
design/dmem_req_decode.sv
ahb_xfer/ahb_req_fifo.sv
ahb_xfer/ahb_xfer_ctrl.sv
design/dmem_resp_align.sv
design/dmem_ahb_bridge.sv
bench/ahb_mem_model.sv
bench/dmem_ahb_tb.sv

//--- Bender.yml
package:
  name: dmem_ahb_bridge

sources:
  - common/dmem_ahb_pkg.sv
  - design/dmem_req_decode.sv
  - ahb_xfer/ahb_req_fifo.sv
  - ahb_xfer/ahb_xfer_ctrl.sv
  - design/dmem_resp_align.sv
  - design/dmem_ahb_bridge.sv
  - target: simulation
    files:
      - bench/ahb_mem_model.sv
      - bench/dmem_ahb_tb.sv

//--- bench/dmem_ahb_tb.sv
// Testbench for the data memory AHB bridge
// Replays load/store patterns against an AHB memory model with random waits

`timescale 1ns/1ps

module dmem_ahb_tb;

    import dmem_ahb_pkg::*;

    localparam int N_PAT      = 18;
    localparam int PAT_WORDS  = 6 * N_PAT;
    localparam int MAX_CYCLES = 20 * N_PAT + 100;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              req_ack;
    mem_req_t          creq;
    logic [DATA_W-1:0] rdata;
    mem_resp_e         resp;
    htrans_e           htrans;
    hsize_e            hsize;
    logic [DATA_W-1:0] haddr;
    logic              hwrite;
    logic [DATA_W-1:0] hwdata;
    logic              hready;
    logic [DATA_W-1:0] hrdata;
    hresp_e            hresp;
    logic [1:0]        wait_states;

    // Six words per pattern in the order cmd width addr wdata exp_rdata exp_resp
    logic [31:0] pat_mem [0:PAT_WORDS-1];
    logic [31:0] lfsr;
    logic        bit_a;
    int          exp_q[$];
    int          n_errors;
    int          n_checks;
    int          done_cnt;
    int          queued;
    int          cycle_cnt;
    int          ack_low_cnt;
    int          idx;

    dmem_ahb_bridge dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .req_ack (req_ack),
        .creq    (creq),
        .rdata   (rdata),
        .resp    (resp),
        .htrans  (htrans),
        .hsize   (hsize),
        .haddr   (haddr),
        .hwrite  (hwrite),
        .hwdata  (hwdata),
        .hready  (hready),
        .hrdata  (hrdata),
        .hresp   (hresp)
    );

    ahb_mem_model mem_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wait_states (wait_states),
        .htrans      (htrans),
        .hsize       (hsize),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .hwdata      (hwdata),
        .hready      (hready),
        .hrdata      (hrdata),
        .hresp       (hresp)
    );

    always #20 clk = ~clk;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic mem_req_t pattern_request(input int i);
        mem_req_t r;
        r.cmd   = mem_cmd_e'(pat_mem[6*i][0]);
        r.width = mem_width_e'(pat_mem[6*i+1][1:0]);
        r.addr  = pat_mem[6*i+2];
        r.wdata = pat_mem[6*i+3];
        return r;
    endfunction

    function automatic string pattern_name(input int i);
        string kind;
        if (pat_mem[6*i][0]) begin
            kind = "store";
        end else begin
            kind = "load";
        end
        return $sformatf("pattern %0d %s width %0d @%08h", i, kind,
                         pat_mem[6*i+1], pat_mem[6*i+2]);
    endfunction

    // Core holds req until the FIFO has room
    task automatic send_request(input int i);
        req  = 1'b1;
        creq = pattern_request(i);
        while (!req_ack) begin
            @(negedge clk);
        end
        exp_q.push_back(i);
        @(negedge clk);
    endtask

    task automatic check_response(input int i);
        mem_resp_e   exp_resp;
        logic [31:0] exp_rdata;
        exp_resp  = mem_resp_e'(pat_mem[6*i+5][1:0]);
        exp_rdata = pat_mem[6*i+4];
        n_checks++;
        if (resp !== exp_resp) begin
            $display("Error %s resp: expected %0d actual %0d", pattern_name(i), exp_resp, resp);
            n_errors++;
        end
        // Read data only counts on an OK load
        if (!pat_mem[6*i][0] && exp_resp == MEM_RESP_RDY_OK && rdata !== exp_rdata) begin
            $display("Error %s rdata: expected %08h actual %08h",
                     pattern_name(i), exp_rdata, rdata);
            n_errors++;
        end
    endtask

    // ----------------------------------------------------------
    // Wait states, cycle limit, monitors
    // ----------------------------------------------------------
    always @(negedge clk) begin
        lfsr  = lfsr_next(lfsr);
        bit_a = lfsr[0];
        lfsr  = lfsr_next(lfsr);
        wait_states = {1'b0, bit_a} + {1'b0, lfsr[0]};
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d responses missing",
                     cycle_cnt, N_PAT - done_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Own FIFO occupancy from accepts and address phases
    always @(posedge clk) begin
        if (!rst_n) begin
            queued = 0;
        end else begin
            n_checks++;
            if (req_ack !== (queued < REQ_DEPTH)) begin
                $display("Error req_ack: expected %0b actual %0b with %0d queued",
                         queued < REQ_DEPTH, req_ack, queued);
                n_errors++;
            end
            // Pipeline stops on an ERROR, no address phase alongside it
            if (hresp == HRESP_ERROR && hready) begin
                n_checks++;
                if (htrans !== HTRANS_IDLE) begin
                    $display("Error error stop htrans: expected %0d actual %0d",
                             HTRANS_IDLE, htrans);
                    n_errors++;
                end
            end
            if (req && !req_ack) begin
                ack_low_cnt++;
            end
            if (req && req_ack) begin
                queued++;
            end
            if (htrans == HTRANS_NONSEQ && hready) begin
                queued--;
            end
        end
    end

    // Responses come back in request order
    always @(posedge clk) begin
        if (rst_n && resp !== MEM_RESP_NOTRDY) begin
            if (exp_q.size() == 0) begin
                $display("Response code %0d arrived with no request outstanding", resp);
                n_errors++;
            end else begin
                idx = exp_q.pop_front();
                check_response(idx);
                done_cnt++;
            end
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = 1'b0;
        creq        = '0;
        wait_states = 2'd0;
        lfsr        = 32'h129a_f262;
        $readmemh("bench/dmem_patterns.hex", pat_mem);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        n_checks++;
        if (htrans !== HTRANS_IDLE || resp !== MEM_RESP_NOTRDY || req_ack !== 1'b1) begin
            $display("Error reset: expected htrans 0 resp 0 req_ack 1 actual %0d %0d %0b",
                     htrans, resp, req_ack);
            n_errors++;
        end

        if ($isunknown(pat_mem[PAT_WORDS-1])) begin
            $display("Pattern file bench/dmem_patterns.hex is missing or too short");
            n_errors++;
        end else begin
            // Back to back requests with no idle cycles between them
            for (int i = 0; i < N_PAT; i++) begin
                send_request(i);
            end
            req  = 1'b0;
            creq = '0;
            while (done_cnt < N_PAT) begin
                @(negedge clk);
            end
            repeat (4) @(negedge clk);
            if (queued != 0) begin
                $display("Requests still queued after the last response");
                n_errors++;
            end
            if (ack_low_cnt == 0) begin
                $display("req_ack never dropped under back-to-back requests");
                n_errors++;
            end
        end

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/ahb_mem_model.sv
// AHB subordinate memory model, 256 words
// Wait states come in per transfer; the top 16 words answer ERROR

`timescale 1ns/1ps

module ahb_mem_model (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [1:0]                      wait_states,
    input  dmem_ahb_pkg::htrans_e           htrans,
    input  dmem_ahb_pkg::hsize_e            hsize,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] haddr,
    input  logic                            hwrite,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] hwdata,
    output logic                            hready,
    output logic [dmem_ahb_pkg::DATA_W-1:0] hrdata,
    output dmem_ahb_pkg::hresp_e            hresp
);

    import dmem_ahb_pkg::*;

    logic [DATA_W-1:0] mem [0:255];
    logic              dp_active;
    logic              dp_write;
    logic              dp_err;
    hsize_e            dp_size;
    logic [7:0]        dp_word;
    logic [1:0]        dp_lane;
    logic [1:0]        wait_left;
    logic [3:0]        byte_en;

    // Fill derived from the word index in every byte
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~i[7:0], i[7:0], ~i[7:0], i[7:0]};
        end
    end

    // ----------------------------------------------------------
    // Data phase outputs
    // ----------------------------------------------------------
    assign hready = !dp_active || (wait_left == 2'd0);
    // ERROR only in the last two cycles of the data phase
    assign hresp  = (dp_active && dp_err && wait_left <= 2'd1) ? HRESP_ERROR : HRESP_OKAY;
    assign hrdata = dp_active ? mem[dp_word] : '0;

    // Byte lanes written by the transfer in its data phase
    always_comb begin
        case (dp_size)
            HSIZE_8B:  byte_en = 4'b0001 << dp_lane;
            HSIZE_16B: byte_en = 4'b0011 << {dp_lane[1], 1'b0};
            default:   byte_en = 4'b1111;
        endcase
    end

    // ----------------------------------------------------------
    // Address phase capture and wait countdown
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dp_active <= 1'b0;
            wait_left <= 2'd0;
        end else if (!hready) begin
            wait_left <= wait_left - 2'd1;
        end else if (htrans == HTRANS_NONSEQ) begin
            dp_active <= 1'b1;
            dp_write  <= hwrite;
            dp_size   <= hsize;
            dp_word   <= haddr[9:2];
            dp_lane   <= haddr[1:0];
            dp_err    <= (haddr[9:6] == 4'hf);
            // ERROR needs a low-hready first cycle
            if (haddr[9:6] == 4'hf && wait_states == 2'd0) begin
                wait_left <= 2'd1;
            end else begin
                wait_left <= wait_states;
            end
        end else begin
            dp_active <= 1'b0;
        end
    end

    // Store commits as the data phase ends
    always @(posedge clk) begin
        if (rst_n && dp_active && hready && dp_write && !dp_err) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[dp_word][8*b +: 8] <= hwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- design/dmem_ahb_bridge.sv
// Data memory to AHB bridge, top level
// Decode, request FIFO, phase controller and response stage

`timescale 1ns/1ps

module dmem_ahb_bridge (
    input  logic                            clk,
    input  logic                            rst_n,
    // Core side
    input  logic                            req,
    output logic                            req_ack,
    input  dmem_ahb_pkg::mem_req_t          creq,
    output logic [dmem_ahb_pkg::DATA_W-1:0] rdata,
    output dmem_ahb_pkg::mem_resp_e         resp,
    // AHB manager side
    output dmem_ahb_pkg::htrans_e           htrans,
    output dmem_ahb_pkg::hsize_e            hsize,
    output logic [dmem_ahb_pkg::DATA_W-1:0] haddr,
    output logic                            hwrite,
    output logic [dmem_ahb_pkg::DATA_W-1:0] hwdata,
    input  logic                            hready,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] hrdata,
    input  dmem_ahb_pkg::hresp_e            hresp
);

    import dmem_ahb_pkg::*;

    logic        push;
    logic        pop;
    logic        full;
    logic        empty;
    logic        data_done;
    ahb_req_t    entry;
    ahb_req_t    head;
    data_phase_t phase;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    assign req_ack = ~full;

    dmem_req_decode decode_i (
        .req   (req),
        .full  (full),
        .creq  (creq),
        .push  (push),
        .entry (entry)
    );

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    ahb_req_fifo fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push),
        .pop   (pop),
        .din   (entry),
        .head  (head),
        .full  (full),
        .empty (empty)
    );

    // Address phase comes straight off the FIFO head
    assign haddr  = head.haddr;
    assign hwrite = head.hwrite;
    assign hsize  = head.hsize;

    ahb_xfer_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .head      (head),
        .hready    (hready),
        .hresp     (hresp),
        .pop       (pop),
        .htrans    (htrans),
        .hwdata    (hwdata),
        .data_done (data_done),
        .phase     (phase)
    );

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    dmem_resp_align resp_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_done (data_done),
        .phase     (phase),
        .hresp     (hresp),
        .hrdata    (hrdata),
        .rdata     (rdata),
        .resp      (resp)
    );

endmodule

//--- design/dmem_resp_align.sv
// Response stage
// Registers the finished data phase and returns aligned read data and status

`timescale 1ns/1ps

module dmem_resp_align (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            data_done,
    input  dmem_ahb_pkg::data_phase_t       phase,
    input  dmem_ahb_pkg::hresp_e            hresp,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] hrdata,
    output logic [dmem_ahb_pkg::DATA_W-1:0] rdata,
    output dmem_ahb_pkg::mem_resp_e         resp
);

    import dmem_ahb_pkg::*;

    ahb_rsp_t          rsp;
    logic              rsp_valid;
    logic [DATA_W-1:0] byte_shift;
    logic [DATA_W-1:0] half_shift;

    // One-cycle ready flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= data_done;
        end
    end

    // Payload captured as the data phase ends
    always_ff @(posedge clk) begin
        if (data_done) begin
            rsp.hresp  <= hresp;
            rsp.phase  <= phase;
            rsp.hrdata <= hrdata;
        end
    end

    // ------------------------------------------------------------
    // Lane alignment back to bit 0
    // ------------------------------------------------------------
    assign byte_shift = rsp.hrdata >> {rsp.phase.lane, 3'b000};
    assign half_shift = rsp.hrdata >> {rsp.phase.lane[1], 4'b0000};

    always_comb begin
        case (rsp.phase.hsize)
            HSIZE_8B:  rdata = {{(DATA_W - 8){1'b0}}, byte_shift[7:0]};
            HSIZE_16B: rdata = {{(DATA_W - 16){1'b0}}, half_shift[15:0]};
            default:   rdata = rsp.hrdata;
        endcase
    end

    // Not ready outside the response cycle
    assign resp = !rsp_valid ? MEM_RESP_NOTRDY :
                  (rsp.hresp == HRESP_OKAY) ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;

endmodule

//--- ahb_xfer/ahb_xfer_ctrl.sv
// AHB address/data phase controller
// Overlaps next address phase with current data phase, drives htrans
// and keeps the data-phase register for hwdata and result alignment

`timescale 1ns/1ps

module ahb_xfer_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         empty,
    input  dmem_ahb_pkg::ahb_req_t       head,
    input  logic                         hready,
    input  dmem_ahb_pkg::hresp_e         hresp,
    output logic                         pop,
    output dmem_ahb_pkg::htrans_e        htrans,
    output logic [dmem_ahb_pkg::DATA_W-1:0] hwdata,
    output logic                         data_done,
    output dmem_ahb_pkg::data_phase_t    phase
);

    import dmem_ahb_pkg::*;

    typedef enum logic {
        ST_ADDR = 1'b0,
        ST_DATA = 1'b1
    } state_e;

    state_e state;
    state_e state_next;
    logic   issue;

    // ------------------------------------------------------------
    // Phase decisions
    // ------------------------------------------------------------
    // Data phase ends on the first hready high cycle
    assign data_done = (state == ST_DATA) & hready;

    // Present an address phase; an ERROR ending holds the head back
    assign issue = ~empty & ((state == ST_ADDR) | (data_done & (hresp == HRESP_OKAY)));
    assign pop    = issue & hready;
    assign htrans = issue ? HTRANS_NONSEQ : HTRANS_IDLE;

    always_comb begin
        case (state)
            ST_ADDR, ST_DATA: begin
                // Accepted address phase moves into data, else back to address
                if (hready) begin
                    state_next = pop ? ST_DATA : ST_ADDR;
                end else begin
                    state_next = state;
                end
            end
            default: begin
                state_next = ST_ADDR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_ADDR;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------------------------------------
    // Data-phase register
    // ------------------------------------------------------------
    // Loaded as the head leaves its address phase
    always_ff @(posedge clk) begin
        if (pop) begin
            hwdata      <= head.hwdata;
            phase.hsize <= head.hsize;
            phase.lane  <= head.haddr[LANE_W-1:0];
        end
    end

endmodule

//--- ahb_xfer/ahb_req_fifo.sv
// AHB request FIFO
// Two-entry shifting queue, head always at slot 0, with count/full/empty

`timescale 1ns/1ps

module ahb_req_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  logic                   pop,
    input  dmem_ahb_pkg::ahb_req_t din,
    output dmem_ahb_pkg::ahb_req_t head,
    output logic                   full,
    output logic                   empty
);

    import dmem_ahb_pkg::*;

    ahb_req_t [REQ_DEPTH-1:0] slots;
    logic     [REQ_CNT_W-1:0] count;

    // ------------------------------------------------------------
    // Status
    // ------------------------------------------------------------
    assign full  = (count == REQ_CNT_W'(REQ_DEPTH));
    assign empty = (count == '0);
    assign head  = slots[0];

    // ------------------------------------------------------------
    // Occupancy count
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10: begin
                    count <= count + REQ_CNT_W'(1);
                end
                2'b01: begin
                    count <= count - REQ_CNT_W'(1);
                end
                default: begin
                    // Idle, or push+pop which keeps the count
                    count <= count;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        case ({push, pop})
            2'b10: begin
                // Write behind whatever is already held
                if (empty) begin
                    slots[0] <= din;
                end else begin
                    slots[1] <= din;
                end
            end
            2'b01: begin
                // Shift second entry up to head
                slots[0] <= slots[1];
            end
            2'b11: begin
                // Only with one entry held; new entry replaces head
                slots[0] <= din;
            end
            default: begin
                slots <= slots;
            end
        endcase
    end

endmodule

//--- design/dmem_req_decode.sv
// Request decode stage
// Turns a core load/store into an AHB request entry with lane-placed data

`timescale 1ns/1ps

module dmem_req_decode (
    input  logic                   req,
    input  logic                   full,
    input  dmem_ahb_pkg::mem_req_t creq,
    output logic                   push,
    output dmem_ahb_pkg::ahb_req_t entry
);

    import dmem_ahb_pkg::*;

    logic [DATA_W-1:0] byte_data;
    logic [DATA_W-1:0] half_data;

    // Taken on the same edge the core sees req_ack
    assign push = req & ~full;

    // Zero-extended store payloads before lane shift
    assign byte_data = {{(DATA_W - 8){1'b0}}, creq.wdata[7:0]};
    assign half_data = {{(DATA_W - 16){1'b0}}, creq.wdata[15:0]};

    always_comb begin
        entry.hwrite = (creq.cmd == MEM_CMD_WR);
        entry.haddr  = creq.addr;
        case (creq.width)
            MEM_WIDTH_BYTE: begin
                entry.hsize  = HSIZE_8B;
                // Byte lane picked by both low address bits
                entry.hwdata = byte_data << {creq.addr[LANE_W-1:0], 3'b000};
            end
            MEM_WIDTH_HWORD: begin
                entry.hsize  = HSIZE_16B;
                // Upper or lower half only
                entry.hwdata = half_data << {creq.addr[1], 4'b0000};
            end
            default: begin
                // Word, and the unused width code
                entry.hsize  = HSIZE_32B;
                entry.hwdata = creq.wdata;
            end
        endcase
    end

endmodule

//--- common/dmem_ahb_pkg.sv
// Data memory AHB bridge package
// Bus widths, core and AHB code constants, request and response structs

package dmem_ahb_pkg;

    // ------------------------------------------------------------
    // Widths and depths
    // ------------------------------------------------------------
    localparam int DATA_W    = 32;
    localparam int LANE_W    = 2;
    localparam int REQ_DEPTH = 2;
    // Count must hold 0..REQ_DEPTH
    localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);

    // ------------------------------------------------------------
    // Core side codes
    // ------------------------------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // ------------------------------------------------------------
    // AHB codes
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        HSIZE_8B  = 3'b000,
        HSIZE_16B = 3'b001,
        HSIZE_32B = 3'b010
    } hsize_e;

    // Single transfers only, so no BUSY or SEQ
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_e;

    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    // Core request as presented with req
    typedef struct packed {
        mem_cmd_e           cmd;
        mem_width_e         width;
        logic [DATA_W-1:0]  addr;
        logic [DATA_W-1:0]  wdata;
    } mem_req_t;

    // One queued AHB transfer, write data already in its lanes
    typedef struct packed {
        logic               hwrite;
        hsize_e             hsize;
        logic [DATA_W-1:0]  haddr;
        logic [DATA_W-1:0]  hwdata;
    } ahb_req_t;

    // What the result stage needs to realign read data
    typedef struct packed {
        hsize_e             hsize;
        logic [LANE_W-1:0]  lane;
    } data_phase_t;

    // One finished data phase
    typedef struct packed {
        hresp_e             hresp;
        data_phase_t        phase;
        logic [DATA_W-1:0]  hrdata;
    } ahb_rsp_t;

endpackage
